//--- source/cpc_mem_pkg.sv
/*
 * Shared widths, types and constants of the CPC memory subsystem.
 * The byte store spans 16 MiB. Bit 23 of an address selects the tape region.
 * Page numbers are 9 bits. Bit 8 selects the upper 4 MiB of expansion ROM.
 */

package cpc_mem_pkg;

	typedef logic [23:0]  mem_addr_t;    // Byte store address
	typedef logic [7:0]   mem_data_t;    // One byte
	typedef logic [24:0]  ioctl_addr_t;  // Host download address
	typedef logic [8:0]   page_t;        // 16 KiB page number
	typedef logic [255:0] rom_map_t;     // One flag per upper ROM page
	typedef logic [15:0]  file_ext_t;    // Last two extension chars

	// In-page offset, 16 KiB pages
	localparam int PAGE_OFFSET_W = 14;

	// Host download indices
	localparam logic [7:0] IDX_ROM  = 8'd0;
	localparam logic [7:0] IDX_EXT  = 8'd3;
	localparam logic [7:0] IDX_TAPE = 8'd4;

	////////////////////////////////////////////////////////////////////////////
	// Fixed pages of the ROM set
	////////////////////////////////////////////////////////////////////////////

	localparam page_t PAGE_OS        = 9'h000;
	localparam page_t PAGE_BASIC     = 9'h100;
	localparam page_t PAGE_AMSDOS    = 9'h107;
	localparam page_t PAGE_MF2       = 9'h0ff;
	localparam page_t PAGE_BAD_EXT   = 9'h1ee;  // Unused page, malformed ext
	localparam page_t PAGE_COMBO_END = 9'h1ff;

	// Address bit that marks the tape region
	localparam int TAPE_BASE_BIT = 23;

endpackage

//--- source/byte_store.sv
/*
 * Single-port byte memory over the whole 16 MiB range.
 * Read is registered every cycle and returns the old byte on a write.
 * Contents are 2-state and start at zero in simulation.
 */

`timescale 1ns/1ps

module byte_store (
	input  logic                  clk_sys,
	input  logic                  we,
	input  cpc_mem_pkg::mem_addr_t addr,
	input  cpc_mem_pkg::mem_data_t wdata,
	output cpc_mem_pkg::mem_data_t rdata
);
	import cpc_mem_pkg::*;

	bit [$bits(mem_data_t)-1:0] mem [0:(1 << $bits(mem_addr_t))-1];

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];  // Read-first
	end

endmodule

//--- source/rom_loader.sv
/*
 * Maps host downloads into the byte store, one cycle behind ioctl_wr.
 * The expansion page is decoded once, on the rising edge of ioctl_download.
 * ROM set blocks 4 to 7 (second model bank) are dropped.
 */

`timescale 1ns/1ps

module rom_loader (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	input  cpc_mem_pkg::file_ext_t   ioctl_file_ext,
	input  logic                     ioctl_wr,
	input  cpc_mem_pkg::ioctl_addr_t ioctl_addr,
	input  cpc_mem_pkg::mem_data_t   ioctl_dout,
	output logic                     boot_wr,
	output cpc_mem_pkg::mem_addr_t   boot_addr,
	output cpc_mem_pkg::mem_data_t   boot_data,
	output logic                     machine_reset,
	output logic                     tape_loading,
	output cpc_mem_pkg::mem_addr_t   tape_last,
	output cpc_mem_pkg::rom_map_t    rom_map
);
	import cpc_mem_pkg::*;

	logic      rom_dl, ext_dl, tape_dl;
	logic      old_download, old_wr;
	logic      combo;
	logic      map_ok;
	page_t     page, map_page;
	mem_addr_t map_addr;
	logic [4:0] digit_hi, digit_lo;

	// {valid, nibble} of one ASCII hex digit
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9") r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F") r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign rom_dl   = ioctl_download & (ioctl_index == IDX_ROM);
	assign ext_dl   = ioctl_download & (ioctl_index == IDX_EXT);
	assign tape_dl  = ioctl_download & (ioctl_index == IDX_TAPE);
	assign digit_hi = hex_digit(ioctl_file_ext[15:8]);
	assign digit_lo = hex_digit(ioctl_file_ext[7:0]);
	assign tape_loading = tape_dl;

	////////////////////////////////////////////////////////////////////////////
	// Download address mapping
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		map_ok   = rom_dl | ext_dl | tape_dl;
		map_page = PAGE_OS;
		if (ext_dl) begin
			map_page = {page[8], page[7:0] + ioctl_addr[PAGE_OFFSET_W +: 8]};
		end else begin
			case (ioctl_addr[$bits(ioctl_addr_t)-1:PAGE_OFFSET_W])
				11'd0:   map_page = PAGE_OS;
				11'd1:   map_page = PAGE_BASIC;
				11'd2:   map_page = PAGE_AMSDOS;
				11'd3:   map_page = PAGE_MF2;
				default: map_ok = tape_dl;  // Second bank and beyond
			endcase
		end
		if (tape_dl) map_addr = {1'b1, ioctl_addr[TAPE_BASE_BIT-1:0]};
		else         map_addr = {1'b0, map_page, ioctl_addr[PAGE_OFFSET_W-1:0]};
	end

	always_ff @(posedge clk_sys) begin
		boot_addr <= map_addr;
		boot_data <= ioctl_dout;
	end

	////////////////////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		machine_reset <= reset | rom_dl | ext_dl;  // Hold the machine off the bus
		if (reset) begin
			boot_wr      <= 1'b0;
			old_download <= 1'b0;
			old_wr       <= 1'b0;
			combo        <= 1'b0;
			page         <= PAGE_OS;
			tape_last    <= '0;
			rom_map      <= '0;
		end else begin
			boot_wr      <= ioctl_wr & map_ok;
			old_download <= ioctl_download;
			old_wr       <= ioctl_wr;
			if (tape_dl && ioctl_wr) tape_last <= map_addr;

			// Byte just written, boot_addr still holds its target
			if (ext_dl && old_wr && !ioctl_wr) begin
				if (boot_addr[22]) rom_map[boot_addr[21:PAGE_OFFSET_W]] <= 1'b1;
				if (combo && &boot_addr[PAGE_OFFSET_W-1:0]) begin
					combo <= 1'b0;
					page  <= PAGE_COMBO_END;
				end
			end

			if (!old_download && ext_dl) begin
				combo <= 1'b0;
				if (ioctl_file_ext == "ZZ") begin
					page <= PAGE_OS;
				end else if (ioctl_file_ext == "Z0") begin
					page  <= PAGE_OS;
					combo <= 1'b1;  // OS page then upper ROMs
				end else if (digit_hi[4] && digit_lo[4]) begin
					page <= {1'b1, digit_hi[3:0], digit_lo[3:0]};
				end else begin
					page <= PAGE_BAD_EXT;
				end
			end
		end
	end

endmodule

//--- source/tape_fetch.sv
/*
 * Serves tape image bytes on toggle handshakes from the player.
 * Requests wait while a tape image is being downloaded.
 * tape_end stays set until the next tape download.
 */

`timescale 1ns/1ps

module tape_fetch (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   tape_loading,
	input  cpc_mem_pkg::mem_addr_t tape_last,
	input  logic                   tape_data_req,
	input  logic                   tape_ack,
	input  cpc_mem_pkg::mem_data_t tape_data,
	output logic                   tape_rd,
	output cpc_mem_pkg::mem_addr_t tape_addr,
	output logic                   tape_data_ack,
	output cpc_mem_pkg::mem_data_t tape_dout,
	output logic                   tape_end
);
	import cpc_mem_pkg::*;

	logic [TAPE_BASE_BIT-1:0] play_ofs;  // Offset inside the tape region
	logic                     old_ack;
	logic                     ack_seen;
	logic                     req_pending;

	assign tape_addr   = {1'b1, play_ofs};
	assign ack_seen    = tape_ack ^ old_ack;
	assign req_pending = tape_data_req ^ tape_data_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			play_ofs      <= '0;
			old_ack       <= 1'b0;
			tape_rd       <= 1'b0;
			tape_data_ack <= 1'b0;
			tape_end      <= 1'b0;
		end else begin
			old_ack <= tape_ack;
			if (tape_loading) begin
				play_ofs <= '0;  // Rewind for the new image
				tape_rd  <= 1'b0;
				tape_end <= 1'b0;
			end else if (tape_rd && ack_seen) begin
				tape_data_ack <= tape_data_req;
				tape_rd       <= 1'b0;
				play_ofs      <= play_ofs + 1'b1;
			end else if (!tape_rd && req_pending) begin
				if (tape_addr <= tape_last) tape_rd  <= 1'b1;
				else                        tape_end <= 1'b1;  // No ack past the end
			end
		end
	end

	// Byte for the player, held until the next ack
	always_ff @(posedge clk_sys) begin
		if (tape_rd && ack_seen) begin
			tape_dout <= tape_data;
		end
	end

endmodule

//--- source/mem_arbiter.sv
/*
 * Fixed priority sharing of the byte store: loader, then CPU, then tape.
 * Loader and CPU are never delayed. A CPU access in the same cycle as a
 * loader write is lost, and the CPU is ignored during machine_reset.
 */

`timescale 1ns/1ps

module mem_arbiter (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   machine_reset,
	input  logic                   boot_wr,
	input  cpc_mem_pkg::mem_addr_t boot_addr,
	input  cpc_mem_pkg::mem_data_t boot_data,
	input  logic                   cpu_rd,
	input  logic                   cpu_wr,
	input  cpc_mem_pkg::mem_addr_t cpu_addr,
	input  cpc_mem_pkg::mem_data_t cpu_dout,
	input  logic                   tape_rd,
	input  cpc_mem_pkg::mem_addr_t tape_addr,
	output cpc_mem_pkg::mem_data_t cpu_din,
	output logic                   tape_ack,
	output cpc_mem_pkg::mem_data_t tape_data,
	output logic                   store_we,
	output cpc_mem_pkg::mem_addr_t store_addr,
	output cpc_mem_pkg::mem_data_t store_wdata,
	input  cpc_mem_pkg::mem_data_t store_rdata
);
	import cpc_mem_pkg::*;

	logic      cpu_go, tape_go;
	logic      last_cpu_rd, last_tape;  // Who owns store_rdata this cycle
	mem_data_t cpu_hold, tape_hold;

	assign cpu_go  = (cpu_rd | cpu_wr) & ~machine_reset & ~boot_wr;
	// Tape only in idle cycles, and not again while its last ack is in flight
	assign tape_go = tape_rd & ~last_tape & ~boot_wr & ~cpu_rd & ~cpu_wr;

	assign store_we    = boot_wr | (cpu_go & cpu_wr);
	assign store_wdata = boot_wr ? boot_data : cpu_dout;

	always_comb begin
		if (boot_wr)      store_addr = boot_addr;
		else if (tape_go) store_addr = tape_addr;
		else              store_addr = cpu_addr;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read data steering
	////////////////////////////////////////////////////////////////////////////

	assign cpu_din   = last_cpu_rd ? store_rdata : cpu_hold;
	assign tape_data = last_tape ? store_rdata : tape_hold;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_cpu_rd <= 1'b0;
			last_tape   <= 1'b0;
			tape_ack    <= 1'b0;
		end else begin
			last_cpu_rd <= cpu_go & cpu_rd;
			last_tape   <= tape_go;
			if (tape_go) tape_ack <= ~tape_ack;  // Seen with the data next cycle
		end
	end

	always_ff @(posedge clk_sys) begin
		if (last_cpu_rd) cpu_hold  <= store_rdata;
		if (last_tape)   tape_hold <= store_rdata;
	end

endmodule

//--- source/cpc_mem_top.sv
/*
 * Memory loading and shared memory of the CPC core.
 * Host download strobes come straight in, no SPI link.
 * Tape player toggles are top level ports.
 */

`timescale 1ns/1ps

module cpc_mem_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	input  cpc_mem_pkg::file_ext_t   ioctl_file_ext,
	input  logic                     ioctl_wr,
	input  cpc_mem_pkg::ioctl_addr_t ioctl_addr,
	input  cpc_mem_pkg::mem_data_t   ioctl_dout,
	input  logic                     cpu_rd,
	input  logic                     cpu_wr,
	input  cpc_mem_pkg::mem_addr_t   cpu_addr,
	input  cpc_mem_pkg::mem_data_t   cpu_dout,
	input  logic                     tape_data_req,
	output cpc_mem_pkg::mem_data_t   cpu_din,
	output logic                     machine_reset,
	output cpc_mem_pkg::rom_map_t    rom_map,
	output cpc_mem_pkg::mem_data_t   tape_dout,
	output logic                     tape_data_ack,
	output logic                     tape_end
);
	import cpc_mem_pkg::*;

	logic      boot_wr, tape_loading, tape_rd, tape_ack, store_we;
	mem_addr_t boot_addr, tape_last, tape_addr, store_addr;
	mem_data_t boot_data, tape_data, store_wdata, store_rdata;

	rom_loader u_loader (
		.clk_sys, .reset, .ioctl_download, .ioctl_index, .ioctl_file_ext,
		.ioctl_wr, .ioctl_addr, .ioctl_dout,
		.boot_wr, .boot_addr, .boot_data,
		.machine_reset, .tape_loading, .tape_last, .rom_map
	);

	tape_fetch u_tape (
		.clk_sys, .reset, .tape_loading, .tape_last,
		.tape_data_req, .tape_ack, .tape_data,
		.tape_rd, .tape_addr, .tape_data_ack, .tape_dout, .tape_end
	);

	////////////////////////////////////////////////////////////////////////////
	// Shared store
	////////////////////////////////////////////////////////////////////////////

	mem_arbiter u_arb (
		.clk_sys, .reset, .machine_reset,
		.boot_wr, .boot_addr, .boot_data,
		.cpu_rd, .cpu_wr, .cpu_addr, .cpu_dout,
		.tape_rd, .tape_addr,
		.cpu_din, .tape_ack, .tape_data,
		.store_we, .store_addr, .store_wdata, .store_rdata
	);

	byte_store u_store (
		.clk_sys,
		.we    (store_we),
		.addr  (store_addr),
		.wdata (store_wdata),
		.rdata (store_rdata)
	);

endmodule

//--- tb/cpc_mem_checker.sv
/*
 * Bus checks on the store arbitration, bound into every mem_arbiter.
 * All checks are idle while reset is high.
 */

`timescale 1ns/1ps

module cpc_mem_checker (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   machine_reset,
	input logic                   boot_wr,
	input cpc_mem_pkg::mem_addr_t boot_addr,
	input cpc_mem_pkg::mem_data_t boot_data,
	input logic                   cpu_rd,
	input logic                   cpu_wr,
	input logic                   tape_ack,
	input logic                   store_we,
	input cpc_mem_pkg::mem_addr_t store_addr,
	input cpc_mem_pkg::mem_data_t store_wdata
);
	// Loader write goes to the store in its own cycle, unchanged
	loader_write: assert property (@(posedge clk_sys) disable iff (reset)
		boot_wr |-> store_we && store_addr == boot_addr && store_wdata == boot_data)
		else $error("loader write did not reach the store in the same cycle");

	// Any other write is a CPU write outside machine reset
	cpu_write: assert property (@(posedge clk_sys) disable iff (reset)
		store_we && !boot_wr |-> cpu_wr && !machine_reset)
		else $error("store written without a loader or an enabled CPU write");

	tape_gap: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_rd || cpu_wr) |=> !$changed(tape_ack))
		else $error("tape_ack toggled right after a CPU access");

	held_off: assert property (@(posedge clk_sys) disable iff (reset)
		machine_reset && cpu_rd && !boot_wr |-> !store_we)
		else $error("CPU read during machine reset wrote the store");

endmodule

bind mem_arbiter cpc_mem_checker u_checker (
	.clk_sys, .reset, .machine_reset, .boot_wr, .boot_addr, .boot_data,
	.cpu_rd, .cpu_wr, .tape_ack, .store_we, .store_addr, .store_wdata
);

//--- tb/cpc_mem_tb.sv
/*
 * Random downloads, CPU traffic and tape playback against a byte model.
 * Host strobes are 4 cycles apart and inputs change 1 ns after the edge.
 */

`timescale 1ns/1ps

module cpc_mem_tb;
	import cpc_mem_pkg::*;

	localparam int        RESET_CYCLES = 16;
	localparam mem_addr_t RAM_BASE     = 24'h020000;  // Lower RAM, clear of the ROM pages

	logic clk_sys, reset, ioctl_download, ioctl_wr, cpu_rd, cpu_wr, tape_data_req;
	logic [7:0] ioctl_index;
	file_ext_t ioctl_file_ext;
	ioctl_addr_t ioctl_addr;
	mem_data_t ioctl_dout, cpu_dout, cpu_din, tape_dout;
	mem_addr_t cpu_addr;
	logic machine_reset, tape_data_ack, tape_end;
	rom_map_t rom_map;

	mem_data_t model [mem_addr_t];  // Expected store contents, absent means 0
	mem_addr_t check_q [$];
	integer seed = 32'h5e07_d871;
	int ops = 0;
	int cycles = 0;

	cpc_mem_top DUT (.*);

	always #10 clk_sys = ~clk_sys;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic mismatch(input string name, input logic [255:0] got, input logic [255:0] exp);
		fail_run($sformatf("FAILED %0t %s got %0h expected %0h", $time, name, got, exp));
	endtask

	function automatic mem_data_t model_byte(input mem_addr_t a);
		return model.exists(a) ? model[a] : 8'h00;
	endfunction

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	// ROM set block to page, blocks 0 to 3 only
	function automatic page_t rom_page(input int blk);
		case (blk)
			0: return PAGE_OS;
			1: return PAGE_BASIC;
			2: return PAGE_AMSDOS;
			default: return PAGE_MF2;
		endcase
	endfunction

	task automatic download_start(input logic [7:0] idx, input file_ext_t ext);
		ioctl_index = idx;
		ioctl_file_ext = ext;
		ioctl_download = 1'b1;
		repeat (2) tick();  // Page decode needs the rising edge first
	endtask

	task automatic download_end();
		ioctl_download = 1'b0;
		repeat (3) tick();
	endtask

	task automatic host_write(input ioctl_addr_t a, input mem_addr_t t, input bit mapped);
		mem_data_t d;
		d = $random(seed);
		ioctl_addr = a;
		ioctl_dout = d;
		ioctl_wr = 1'b1;
		tick();
		ioctl_wr = 1'b0;
		if (mapped) model[t] = d;
		if (ioctl_index != IDX_TAPE)
			assert (machine_reset === 1'b1) else fail_run("machine_reset low during a ROM download");
		repeat (3) tick();
		ops++;
	endtask

	task automatic cpu_read_check(input mem_addr_t a);
		cpu_addr = a;
		cpu_rd = 1'b1;
		tick();
		cpu_rd = 1'b0;
		assert (cpu_din === model_byte(a)) else mismatch("cpu_din", cpu_din, model_byte(a));
		ops++;
	endtask

	task automatic cpu_write(input mem_addr_t a, input mem_data_t d);
		cpu_addr = a;
		cpu_dout = d;
		cpu_wr = 1'b1;
		tick();
		cpu_wr = 1'b0;
		model[a] = d;
		ops++;
	endtask

	task automatic cpu_random_op();
		mem_addr_t a;
		a = RAM_BASE + ($unsigned($random(seed)) % 256);  // Small range for read hits
		if ($random(seed) & 1) cpu_write(a, $random(seed));
		else cpu_read_check(a);
	endtask

	task automatic verify_checked();
		foreach (check_q[i]) cpu_read_check(check_q[i]);
		check_q.delete();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Watchdog, 200 cycles per issued operation
	////////////////////////////////////////////////////////////////////////////

	initial begin
		forever begin
			@(posedge clk_sys);
			cycles++;
			if (cycles > RESET_CYCLES + 200 * (ops + 1))
				fail_run("watchdog expired, the DUT stopped answering");
		end
	end

	initial begin
		ioctl_addr_t a;
		mem_addr_t t;
		logic [13:0] ofs;
		file_ext_t ext_name [4];
		page_t ext_page [4];
		rom_map_t exp_map;
		int n;
		int wait_cnt;
		bit done;

		clk_sys = 1'b0;
		reset = 1'b1;
		{ioctl_download, ioctl_wr, cpu_rd, cpu_wr, tape_data_req} = '0;
		ioctl_index = '0;
		ioctl_file_ext = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		cpu_addr = '0;
		cpu_dout = '0;
		repeat (RESET_CYCLES) tick();
		assert (machine_reset === 1'b1 && tape_end === 1'b0 && tape_data_ack === 1'b0
			&& rom_map === '0) else fail_run("outputs not in their reset state");
		reset = 1'b0;

		// ROM set, blocks 4 to 7 must not land anywhere
		download_start(IDX_ROM, "  ");
		for (int blk = 0; blk < 8; blk++) begin
			for (int k = 0; k < 6; k++) begin
				ofs = $random(seed);
				a = (blk << PAGE_OFFSET_W) | ofs;
				t = {rom_page(blk % 4), ofs};  // Upper blocks probe their alias page
				host_write(a, t, blk < 4);
				check_q.push_back(t);
				if (blk >= 4) check_q.push_back({PAGE_OS, ofs});  // Unmapped decode falls to OS
			end
		end
		download_end();
		verify_checked();

		ext_name = '{"0A", "1F", "ZZ", "Q!"};
		ext_page = '{9'h10a, 9'h11f, 9'h000, 9'h1ee};
		for (int e = 0; e < 4; e++) begin
			download_start(IDX_EXT, ext_name[e]);
			repeat (4) begin
				ofs = $random(seed);
				t = {ext_page[e], ofs};
				host_write(ofs, t, 1'b1);
				check_q.push_back(t);
			end
			download_end();
		end
		verify_checked();
		exp_map = '0;
		exp_map[8'h0a] = 1'b1;
		exp_map[8'h1f] = 1'b1;
		exp_map[8'hee] = 1'b1;
		assert (rom_map === exp_map) else mismatch("rom_map", rom_map, exp_map);

		repeat (80) cpu_random_op();

		////////////////////////////////////////////////////////////////////////
		// Tape image and playback under CPU traffic
		////////////////////////////////////////////////////////////////////////

		n = 20 + $unsigned($random(seed)) % 41;
		download_start(IDX_TAPE, "  ");
		for (int i = 0; i < n; i++) host_write(i, {1'b1, 23'(i)}, 1'b1);
		download_end();
		done = 1'b0;
		fork
			begin
				for (int i = 0; i <= n; i++) begin
					tape_data_req = ~tape_data_req;
					ops++;
					wait_cnt = 0;
					while (tape_data_ack !== tape_data_req && tape_end !== 1'b1) begin
						tick();
						wait_cnt++;
						if (wait_cnt > 200) fail_run("tape request was never answered");
					end
					t = {1'b1, 23'(i)};
					if (i < n) begin
						assert (tape_end === 1'b0) else fail_run("tape_end set before the last byte");
						assert (tape_dout === model_byte(t))
							else mismatch("tape_dout", tape_dout, model_byte(t));
					end
				end
				repeat (4) tick();  // Past the end, no ack may follow
				assert (tape_end === 1'b1 && tape_data_ack !== tape_data_req)
					else fail_run("request past the last tape byte was acknowledged");
				done = 1'b1;
			end
			begin
				while (!done) begin
					if ($random(seed) & 1) cpu_random_op();
					else tick();
				end
			end
		join

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- flist.f
source/cpc_mem_pkg.sv
source/byte_store.sv
source/rom_loader.sv
source/tape_fetch.sv
source/mem_arbiter.sv
source/cpc_mem_top.sv
tb/cpc_mem_checker.sv
tb/cpc_mem_tb.sv
